/* hdl/axi_mem_pkg.sv */
package axi_mem_pkg;

    // bus geometry shared by every block
    localparam int ID_WIDTH   = 4;
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 64;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // byte offset bits inside one full-width beat
    localparam int ADDR_LSB   = $clog2(STRB_WIDTH);

    // beat-granular word index width
    localparam int WORD_WIDTH = ADDR_WIDTH - ADDR_LSB;

    typedef logic [WORD_WIDTH-1:0] word_idx_t;

    // AxBURST encodings, reserved code steps like incr
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10,
        BURST_RSVD  = 2'b11
    } burst_e;

    // only response this slave ever returns
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // one address channel request, len is beats minus one
    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [7:0]            len;
        burst_e                burst;
    } burst_cmd_t;

    // write command broadcast to all byte lanes
    typedef struct packed {
        logic [STRB_WIDTH-1:0] en;
        word_idx_t             idx;
        logic [DATA_WIDTH-1:0] data;
    } lane_wr_t;

    // read command broadcast to all byte lanes
    typedef struct packed {
        logic      en;
        word_idx_t idx;
    } lane_rd_t;

endpackage

/* hdl/burst_addr_gen.sv */
module burst_addr_gen #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                    S_AXI_ACLK,
    input  logic                    S_AXI_ARESETN,
    input  logic                    load,
    input  axi_mem_pkg::burst_cmd_t cmd,
    input  logic                    step,
    output axi_mem_pkg::word_idx_t  word_index,
    output logic                    last_beat
);

    // depth is a power of two so the modulo is a mask
    localparam axi_mem_pkg::word_idx_t DEPTH_MASK = axi_mem_pkg::word_idx_t'(MEM_DEPTH - 1);

    axi_mem_pkg::word_idx_t cur_word;
    axi_mem_pkg::word_idx_t cur_plus;
    axi_mem_pkg::word_idx_t wrap_mask;
    axi_mem_pkg::word_idx_t next_word;
    axi_mem_pkg::burst_e    burst_q;
    logic [7:0]             len_q;
    logic [7:0]             beat_cnt;
    // set once the final beat has been stepped past
    logic                   burst_done;

    assign cur_plus  = cur_word + axi_mem_pkg::word_idx_t'(1);
    // wrap block is len+1 beats, len is 2^n-1 for a legal wrap
    assign wrap_mask = axi_mem_pkg::word_idx_t'(len_q);

    always_comb
    begin
        case (burst_q)
            axi_mem_pkg::BURST_FIXED: next_word = cur_word;
            // keep the block base, roll the offset bits inside the block
            axi_mem_pkg::BURST_WRAP:  next_word = (cur_word & ~wrap_mask) | (cur_plus & wrap_mask);
            default:                  next_word = cur_plus;
        endcase
    end

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            burst_q    <= axi_mem_pkg::BURST_INCR;
            len_q      <= '0;
            beat_cnt   <= '0;
            burst_done <= 1'b0;
        end
        else if (load)
        begin
            burst_q    <= cmd.burst;
            len_q      <= cmd.len;
            beat_cnt   <= '0;
            burst_done <= 1'b0;
        end
        else if (step)
        begin
            beat_cnt   <= beat_cnt + 8'd1;
            burst_done <= last_beat;
        end
    end

    // start address drops its byte offset, beats are full width
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (load)
        begin
            cur_word <= cmd.addr[axi_mem_pkg::ADDR_WIDTH-1:axi_mem_pkg::ADDR_LSB];
        end
        else if (step)
        begin
            cur_word <= next_word;
        end
    end

    assign word_index = cur_word & DEPTH_MASK;
    assign last_beat  = (beat_cnt == len_q);

    // wrap bursts must cover 2, 4, 8 or 16 beats
    wrap_len_legal: assert property (
        @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (load && cmd.burst == axi_mem_pkg::BURST_WRAP) |-> (cmd.len inside {8'd1, 8'd3, 8'd7, 8'd15})
    );

    // the owning channel stops stepping after the final beat until the next load
    no_step_after_last: assert property (
        @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        step |-> !burst_done
    );

endmodule

/* hdl/mem_byte_lane.sv */
module mem_byte_lane #(
    parameter int MEM_DEPTH = 256,
    parameter int LANE      = 0
) (
    input  logic                  S_AXI_ACLK,
    input  axi_mem_pkg::lane_wr_t wr,
    input  axi_mem_pkg::lane_rd_t rd,
    output logic [7:0]            rd_byte
);

    localparam int IDX_BITS = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

    logic [7:0]          mem [MEM_DEPTH];
    logic [IDX_BITS-1:0] wr_addr;
    logic [IDX_BITS-1:0] rd_addr;

    // low index bits only, the word index wraps at the depth
    assign wr_addr = wr.idx[IDX_BITS-1:0];
    assign rd_addr = rd.idx[IDX_BITS-1:0];

    // this lane owns strobe bit LANE and data byte LANE
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (wr.en[LANE])
        begin
            mem[wr_addr] <= wr.data[LANE*8 +: 8];
        end
    end

    // registered read port, output holds when no read is issued
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (rd.en)
        begin
            rd_byte <= mem[rd_addr];
        end
    end

endmodule

/* hdl/axi_write_channel.sv */
module axi_write_channel #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                                S_AXI_ACLK,
    input  logic                                S_AXI_ARESETN,
    input  logic                                aw_valid,
    input  axi_mem_pkg::burst_cmd_t             aw_cmd,
    input  logic                                w_valid,
    input  logic [axi_mem_pkg::DATA_WIDTH-1:0]  w_data,
    input  logic [axi_mem_pkg::STRB_WIDTH-1:0]  w_strb,
    input  logic                                w_last,
    input  logic                                b_ready,
    input  logic                                rd_busy,
    output logic                                aw_ready,
    output logic                                w_ready,
    output logic                                b_valid,
    output logic [axi_mem_pkg::ID_WIDTH-1:0]    b_id,
    output logic [1:0]                          b_resp,
    output logic                                wr_busy,
    output axi_mem_pkg::lane_wr_t               lane_wr
);

    // one state per phase, handshake outputs decode straight from it
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    wr_state_e              state;
    logic                   aw_hs;
    logic                   w_hs;
    axi_mem_pkg::word_idx_t word_index;
    logic                   last_beat;

    assign aw_ready = (state == WR_ADDR);
    assign w_ready  = (state == WR_DATA);
    assign b_valid  = (state == WR_RESP);
    assign b_resp   = axi_mem_pkg::RESP_OKAY;

    assign aw_hs = aw_valid && aw_ready;
    assign w_hs  = w_valid && w_ready;

    // a pending aw already blocks the read grant, this gives write priority
    assign wr_busy = (state != WR_IDLE) || aw_valid;

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            state <= WR_IDLE;
        end
        else
        begin
            case (state)
                WR_IDLE:
                begin
                    // wait for the read side to drain first
                    if (aw_valid && !rd_busy)
                    begin
                        state <= WR_ADDR;
                    end
                end
                WR_ADDR:
                begin
                    if (aw_hs)
                    begin
                        state <= WR_DATA;
                    end
                end
                WR_DATA:
                begin
                    if (w_hs && w_last)
                    begin
                        state <= WR_RESP;
                    end
                end
                default:
                begin
                    if (b_ready)
                    begin
                        state <= WR_IDLE;
                    end
                end
            endcase
        end
    end

    // echo the request id on B
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (aw_hs)
        begin
            b_id <= aw_cmd.id;
        end
    end

    burst_addr_gen #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_addr_gen (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .load          (aw_hs),
        .cmd           (aw_cmd),
        .step          (w_hs),
        .word_index    (word_index),
        .last_beat     (last_beat)
    );

    // strobes become the per-lane write enables on an accepted beat only
    always_comb
    begin
        lane_wr.en   = w_hs ? w_strb : '0;
        lane_wr.idx  = word_index;
        lane_wr.data = w_data;
    end

    // master's wlast must agree with the beat count from the aw len
    wlast_on_final_beat: assert property (
        @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        w_hs |-> (w_last == last_beat)
    );

endmodule

/* hdl/axi_read_channel.sv */
module axi_read_channel #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                                S_AXI_ACLK,
    input  logic                                S_AXI_ARESETN,
    input  logic                                ar_valid,
    input  axi_mem_pkg::burst_cmd_t             ar_cmd,
    input  logic                                r_ready,
    input  logic                                wr_busy,
    input  logic [axi_mem_pkg::DATA_WIDTH-1:0]  lane_data,
    output logic                                ar_ready,
    output logic                                r_valid,
    output logic [axi_mem_pkg::ID_WIDTH-1:0]    r_id,
    output logic [axi_mem_pkg::DATA_WIDTH-1:0]  r_data,
    output logic [1:0]                          r_resp,
    output logic                                r_last,
    output logic                                rd_busy,
    output axi_mem_pkg::lane_rd_t               lane_rd
);

    // fetch issues the lane read, data presents the registered word
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_FETCH,
        RD_DATA
    } rd_state_e;

    rd_state_e              state;
    logic                   ar_hs;
    logic                   r_hs;
    axi_mem_pkg::word_idx_t word_index;
    logic                   last_beat;

    assign ar_ready = (state == RD_ADDR);
    assign r_valid  = (state == RD_DATA);
    assign r_resp   = axi_mem_pkg::RESP_OKAY;
    assign rd_busy  = (state != RD_IDLE);

    assign ar_hs = ar_valid && ar_ready;
    assign r_hs  = r_valid && r_ready;

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            state <= RD_IDLE;
        end
        else
        begin
            case (state)
                RD_IDLE:
                begin
                    // wr_busy also covers an aw arriving this very cycle
                    if (ar_valid && !wr_busy)
                    begin
                        state <= RD_ADDR;
                    end
                end
                RD_ADDR:
                begin
                    if (ar_hs)
                    begin
                        state <= RD_FETCH;
                    end
                end
                RD_FETCH:
                begin
                    state <= RD_DATA;
                end
                default:
                begin
                    if (r_hs)
                    begin
                        // one bubble cycle for the next lane read
                        state <= last_beat ? RD_IDLE : RD_FETCH;
                    end
                end
            endcase
        end
    end

    // echo the request id on R
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (ar_hs)
        begin
            r_id <= ar_cmd.id;
        end
    end

    // address advances on the R handshake, ready for the next fetch
    burst_addr_gen #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_addr_gen (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .load          (ar_hs),
        .cmd           (ar_cmd),
        .step          (r_hs),
        .word_index    (word_index),
        .last_beat     (last_beat)
    );

    always_comb
    begin
        lane_rd.en  = (state == RD_FETCH);
        lane_rd.idx = word_index;
    end

    // lanes hold their output register between reads, so data is steady
    assign r_data = r_valid ? lane_data : '0;
    assign r_last = r_valid && last_beat;

    // a stalled beat keeps its data until taken, across the lane registers
    r_hold_under_stall: assert property (
        @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        (r_valid && !r_ready) |=> (r_valid && $stable(r_data))
    );

endmodule

/* hdl/axi_mem_top.sv */
module axi_mem_top #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                                S_AXI_ACLK,
    input  logic                                S_AXI_ARESETN,
    input  logic                                S_AXI_AWVALID,
    output logic                                S_AXI_AWREADY,
    input  logic [axi_mem_pkg::ID_WIDTH-1:0]    S_AXI_AWID,
    input  logic [axi_mem_pkg::ADDR_WIDTH-1:0]  S_AXI_AWADDR,
    input  logic [7:0]                          S_AXI_AWLEN,
    input  logic [1:0]                          S_AXI_AWBURST,
    input  logic                                S_AXI_WVALID,
    output logic                                S_AXI_WREADY,
    input  logic [axi_mem_pkg::DATA_WIDTH-1:0]  S_AXI_WDATA,
    input  logic [axi_mem_pkg::STRB_WIDTH-1:0]  S_AXI_WSTRB,
    input  logic                                S_AXI_WLAST,
    output logic                                S_AXI_BVALID,
    input  logic                                S_AXI_BREADY,
    output logic [axi_mem_pkg::ID_WIDTH-1:0]    S_AXI_BID,
    output logic [1:0]                          S_AXI_BRESP,
    input  logic                                S_AXI_ARVALID,
    output logic                                S_AXI_ARREADY,
    input  logic [axi_mem_pkg::ID_WIDTH-1:0]    S_AXI_ARID,
    input  logic [axi_mem_pkg::ADDR_WIDTH-1:0]  S_AXI_ARADDR,
    input  logic [7:0]                          S_AXI_ARLEN,
    input  logic [1:0]                          S_AXI_ARBURST,
    output logic                                S_AXI_RVALID,
    input  logic                                S_AXI_RREADY,
    output logic [axi_mem_pkg::ID_WIDTH-1:0]    S_AXI_RID,
    output logic [axi_mem_pkg::DATA_WIDTH-1:0]  S_AXI_RDATA,
    output logic [1:0]                          S_AXI_RRESP,
    output logic                                S_AXI_RLAST
);

    axi_mem_pkg::burst_cmd_t               aw_cmd;
    axi_mem_pkg::burst_cmd_t               ar_cmd;
    axi_mem_pkg::lane_wr_t                 lane_wr;
    axi_mem_pkg::lane_rd_t                 lane_rd;
    logic [axi_mem_pkg::DATA_WIDTH-1:0]    lane_data;
    logic                                  wr_busy;
    logic                                  rd_busy;

    // address channel fields packed into one command each
    assign aw_cmd = '{id: S_AXI_AWID, addr: S_AXI_AWADDR, len: S_AXI_AWLEN,
                      burst: axi_mem_pkg::burst_e'(S_AXI_AWBURST)};
    assign ar_cmd = '{id: S_AXI_ARID, addr: S_AXI_ARADDR, len: S_AXI_ARLEN,
                      burst: axi_mem_pkg::burst_e'(S_AXI_ARBURST)};

    axi_write_channel #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_write (
        .S_AXI_ACLK (S_AXI_ACLK), .S_AXI_ARESETN (S_AXI_ARESETN),
        .aw_valid (S_AXI_AWVALID), .aw_cmd (aw_cmd),
        .w_valid (S_AXI_WVALID), .w_data (S_AXI_WDATA),
        .w_strb (S_AXI_WSTRB), .w_last (S_AXI_WLAST),
        .b_ready (S_AXI_BREADY), .rd_busy (rd_busy),
        .aw_ready (S_AXI_AWREADY), .w_ready (S_AXI_WREADY),
        .b_valid (S_AXI_BVALID), .b_id (S_AXI_BID), .b_resp (S_AXI_BRESP),
        .wr_busy (wr_busy), .lane_wr (lane_wr)
    );

    axi_read_channel #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_read (
        .S_AXI_ACLK (S_AXI_ACLK), .S_AXI_ARESETN (S_AXI_ARESETN),
        .ar_valid (S_AXI_ARVALID), .ar_cmd (ar_cmd),
        .r_ready (S_AXI_RREADY), .wr_busy (wr_busy), .lane_data (lane_data),
        .ar_ready (S_AXI_ARREADY), .r_valid (S_AXI_RVALID), .r_id (S_AXI_RID),
        .r_data (S_AXI_RDATA), .r_resp (S_AXI_RRESP), .r_last (S_AXI_RLAST),
        .rd_busy (rd_busy), .lane_rd (lane_rd)
    );

    // one byte-wide RAM per strobe bit, bytes rejoin in lane order
    for (genvar k = 0; k < axi_mem_pkg::STRB_WIDTH; k++)
    begin : g_lane
        mem_byte_lane #(
            .MEM_DEPTH (MEM_DEPTH),
            .LANE      (k)
        ) u_lane (
            .S_AXI_ACLK (S_AXI_ACLK),
            .wr         (lane_wr),
            .rd         (lane_rd),
            .rd_byte    (lane_data[k*8 +: 8])
        );
    end

endmodule

/* verif/tb_clock_gen.sv */
module tb_clock_gen (
    output logic S_AXI_ACLK,
    output logic S_AXI_ARESETN
);

    // free running clock, period of 4
    initial
    begin
        S_AXI_ACLK = 1'b0;
        forever #2 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    // reset held low for the first 5 rising edges
    initial
    begin
        S_AXI_ARESETN = 1'b0;
        repeat (5) @(posedge S_AXI_ACLK);
        S_AXI_ARESETN <= 1'b1;
    end

endmodule

/* verif/tb_axi_mem.sv */
module tb_axi_mem;

    localparam int MEM_DEPTH = 256;
    // cycles allowed for any single wait
    localparam int TIMEOUT   = 200;
    // AXI OKAY response code
    localparam logic [1:0] OKAY = 2'b00;

    // one expected R beat
    typedef struct packed {
        logic [3:0]  id;
        logic [63:0] data;
        logic        last;
    } r_beat_t;

    logic        S_AXI_ACLK;
    logic        S_AXI_ARESETN;
    logic        aw_valid;
    logic        aw_ready;
    logic [3:0]  aw_id;
    logic [31:0] aw_addr;
    logic [7:0]  aw_len;
    logic [1:0]  aw_burst;
    logic        w_valid;
    logic        w_ready;
    logic [63:0] w_data;
    logic [7:0]  w_strb;
    logic        w_last;
    logic        b_valid;
    logic        b_ready;
    logic [3:0]  b_id;
    logic [1:0]  b_resp;
    logic        ar_valid;
    logic        ar_ready;
    logic [3:0]  ar_id;
    logic [31:0] ar_addr;
    logic [7:0]  ar_len;
    logic [1:0]  ar_burst;
    logic        r_valid;
    logic        r_ready;
    logic [3:0]  r_id;
    logic [63:0] r_data;
    logic [1:0]  r_resp;
    logic        r_last;

    integer      seed = 32'h7ad0_a7ab;
    int          error_count = 0;
    int          timeout_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          b_cycle = 0;
    int          ar_cycle = 0;

    // reference memory updated byte by byte through the strobes
    logic [63:0] ref_mem [MEM_DEPTH];
    // beats of the next write burst
    logic [63:0] wbeat_data [256];
    logic [7:0]  wbeat_strb [256];
    r_beat_t     exp_q [$];
    r_beat_t     want;
    logic        b_stalled;
    logic        r_stalled;
    logic [63:0] r_data_q;

    tb_clock_gen clk_gen (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN)
    );

    axi_mem_top #(
        .MEM_DEPTH (MEM_DEPTH)
    ) dut0 (
        .S_AXI_ACLK (S_AXI_ACLK), .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWVALID (aw_valid), .S_AXI_AWREADY (aw_ready), .S_AXI_AWID (aw_id),
        .S_AXI_AWADDR (aw_addr), .S_AXI_AWLEN (aw_len), .S_AXI_AWBURST (aw_burst),
        .S_AXI_WVALID (w_valid), .S_AXI_WREADY (w_ready), .S_AXI_WDATA (w_data),
        .S_AXI_WSTRB (w_strb), .S_AXI_WLAST (w_last),
        .S_AXI_BVALID (b_valid), .S_AXI_BREADY (b_ready), .S_AXI_BID (b_id),
        .S_AXI_BRESP (b_resp),
        .S_AXI_ARVALID (ar_valid), .S_AXI_ARREADY (ar_ready), .S_AXI_ARID (ar_id),
        .S_AXI_ARADDR (ar_addr), .S_AXI_ARLEN (ar_len), .S_AXI_ARBURST (ar_burst),
        .S_AXI_RVALID (r_valid), .S_AXI_RREADY (r_ready), .S_AXI_RID (r_id),
        .S_AXI_RDATA (r_data), .S_AXI_RRESP (r_resp), .S_AXI_RLAST (r_last)
    );

    always @(posedge S_AXI_ACLK)
    begin
        cycle_count <= cycle_count + 1;
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp_val);
        error_count++;
        $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp_val);
    endtask

    task automatic report_problem(input string what);
        error_count++;
        $display("ERROR: %s", what);
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("TIMEOUT: %s", what);
    endtask

    // expected word index of one beat from the burst rules
    function automatic int ref_word_index(input logic [31:0] addr, input int len,
                                          input logic [1:0] burst, input int beat);
        int start;
        int size;
        int base;
        int idx;
        // byte offset inside the beat is ignored
        start = int'(addr >> 3);
        size  = len + 1;
        case (burst)
            2'b00:
            begin
                idx = start;
            end
            2'b10:
            begin
                // roll back to the start of the aligned block of len+1 beats
                base = (start / size) * size;
                idx  = base + ((start - base + beat) % size);
            end
            default:
            begin
                idx = start + beat;
            end
        endcase
        return idx % MEM_DEPTH;
    endfunction

    // random beats for the next write are mirrored into the model here
    task automatic prep_write(input logic [31:0] addr, input int len,
                              input logic [1:0] burst, input bit rand_strb);
        int          beat;
        int          k;
        int          w;
        logic [31:0] lo;
        logic [31:0] hi;
        for (beat = 0; beat <= len; beat++)
        begin
            lo = $random(seed);
            hi = $random(seed);
            wbeat_data[beat] = {hi, lo};
            wbeat_strb[beat] = rand_strb ? 8'($random(seed)) : 8'hff;
            w = ref_word_index(addr, len, burst, beat);
            for (k = 0; k < 8; k++)
            begin
                if (wbeat_strb[beat][k])
                begin
                    ref_mem[w][k*8 +: 8] = wbeat_data[beat][k*8 +: 8];
                end
            end
        end
    endtask

    task automatic drive_write(input logic [3:0] id, input logic [31:0] addr, input int len,
                               input logic [1:0] burst, input bit stall);
        int beat;
        int t;
        bit done;
        aw_valid <= 1'b1;
        aw_id    <= id;
        aw_addr  <= addr;
        aw_len   <= 8'(len);
        aw_burst <= burst;
        t = 0;
        do
        begin
            @(posedge S_AXI_ACLK);
            t++;
        end
        while (!(aw_valid && aw_ready) && t < TIMEOUT);
        aw_valid <= 1'b0;
        if (!(aw_valid && aw_ready))
        begin
            report_timeout("AWREADY never rose for a write burst");
            return;
        end
        // first beat goes out on the AW handshake edge
        for (beat = 0; beat <= len; beat++)
        begin
            w_valid <= 1'b1;
            w_data  <= wbeat_data[beat];
            w_strb  <= wbeat_strb[beat];
            w_last  <= (beat == len);
            t = 0;
            do
            begin
                @(posedge S_AXI_ACLK);
                t++;
            end
            while (!(w_valid && w_ready) && t < TIMEOUT);
            if (!(w_valid && w_ready))
            begin
                report_timeout("WREADY stayed low during a write burst");
                w_valid <= 1'b0;
                w_last  <= 1'b0;
                return;
            end
        end
        w_valid <= 1'b0;
        w_last  <= 1'b0;
        // B with optional random back-pressure
        b_ready <= stall ? 1'($random(seed)) : 1'b1;
        done = 1'b0;
        t = 0;
        do
        begin
            @(posedge S_AXI_ACLK);
            t++;
            done = b_valid && b_ready;
            if (!done)
            begin
                b_ready <= stall ? 1'($random(seed)) : 1'b1;
            end
        end
        while (!done && t < TIMEOUT);
        b_ready <= 1'b0;
        if (!done)
        begin
            report_timeout("no write response arrived");
            return;
        end
        b_cycle = cycle_count;
        check_count += 2;
        assert (b_id == id) else report_mismatch("S_AXI_BID", b_id, id);
        assert (b_resp == OKAY) else report_mismatch("S_AXI_BRESP", b_resp, OKAY);
    endtask

    task automatic drive_read(input logic [3:0] id, input logic [31:0] addr, input int len,
                              input logic [1:0] burst, input bit stall);
        r_beat_t beat_exp;
        int      beat;
        int      t;
        bit      done;
        // expected beats are queued for the checking process
        for (beat = 0; beat <= len; beat++)
        begin
            beat_exp.id   = id;
            beat_exp.data = ref_mem[ref_word_index(addr, len, burst, beat)];
            beat_exp.last = (beat == len);
            exp_q.push_back(beat_exp);
        end
        ar_valid <= 1'b1;
        ar_id    <= id;
        ar_addr  <= addr;
        ar_len   <= 8'(len);
        ar_burst <= burst;
        t = 0;
        do
        begin
            @(posedge S_AXI_ACLK);
            t++;
        end
        while (!(ar_valid && ar_ready) && t < TIMEOUT);
        ar_valid <= 1'b0;
        if (!(ar_valid && ar_ready))
        begin
            report_timeout("ARREADY never rose for a read burst");
            exp_q.delete();
            return;
        end
        ar_cycle = cycle_count;
        r_ready <= stall ? 1'($random(seed)) : 1'b1;
        done = 1'b0;
        t = 0;
        do
        begin
            @(posedge S_AXI_ACLK);
            t++;
            done = r_valid && r_ready && r_last;
            if (!done)
            begin
                r_ready <= stall ? 1'($random(seed)) : 1'b1;
            end
        end
        while (!done && t < TIMEOUT);
        r_ready <= 1'b0;
        if (!done)
        begin
            report_timeout("no RLAST beat arrived for a read burst");
            exp_q.delete();
            return;
        end
        // one more edge so the checker has taken the last beat
        @(posedge S_AXI_ACLK);
        check_count++;
        assert (exp_q.size() == 0) else report_problem("read burst ended with beats missing");
        exp_q.delete();
    endtask

    // compares every R beat and watches stalled responses
    always @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            b_stalled <= 1'b0;
            r_stalled <= 1'b0;
        end
        else
        begin
            if (b_stalled)
            begin
                check_count++;
                assert (b_valid) else report_problem("BVALID dropped before BREADY");
            end
            if (r_stalled)
            begin
                check_count += 2;
                assert (r_valid) else report_problem("RVALID dropped before RREADY");
                assert (r_data == r_data_q)
                    else report_mismatch("S_AXI_RDATA", r_data, r_data_q);
            end
            if (r_valid && r_ready)
            begin
                if (exp_q.size() == 0)
                begin
                    report_problem("R beat arrived with no read outstanding");
                end
                else
                begin
                    want = exp_q.pop_front();
                    check_count += 4;
                    assert (r_data == want.data)
                        else report_mismatch("S_AXI_RDATA", r_data, want.data);
                    assert (r_id == want.id)
                        else report_mismatch("S_AXI_RID", r_id, want.id);
                    assert (r_last == want.last)
                        else report_mismatch("S_AXI_RLAST", r_last, want.last);
                    assert (r_resp == OKAY)
                        else report_mismatch("S_AXI_RRESP", r_resp, OKAY);
                end
            end
            b_stalled <= b_valid && !b_ready;
            r_stalled <= r_valid && !r_ready;
            r_data_q  <= r_data;
        end
    end

    initial
    begin
        int          i;
        int          t;
        int          len;
        logic [31:0] addr;
        logic [3:0]  id;
        logic [5:0]  status;
        {aw_valid, aw_id, aw_addr, aw_len, aw_burst} = '0;
        {w_valid, w_data, w_strb, w_last, b_ready} = '0;
        {ar_valid, ar_id, ar_addr, ar_len, ar_burst, r_ready} = '0;
        t = 0;
        while (!S_AXI_ARESETN && t < TIMEOUT)
        begin
            @(posedge S_AXI_ACLK);
            t++;
        end
        if (!S_AXI_ARESETN)
        begin
            report_timeout("reset was never released");
        end
        // all handshake outputs idle out of reset
        status = {aw_ready, w_ready, b_valid, ar_ready, r_valid, r_last};
        check_count++;
        assert (status == 6'd0)
            else report_mismatch("{AWREADY,WREADY,BVALID,ARREADY,RVALID,RLAST}", status, 0);
        // fill every word with full-strobe INCR bursts and read them back
        for (i = 0; i < MEM_DEPTH / 16; i++)
        begin
            prep_write(32'(i * 128), 15, axi_mem_pkg::BURST_INCR, 1'b0);
            drive_write(4'(i), 32'(i * 128), 15, axi_mem_pkg::BURST_INCR, 1'b0);
        end
        for (i = 0; i < MEM_DEPTH / 16; i++)
        begin
            drive_read(4'(15 - i), 32'(i * 128), 15, axi_mem_pkg::BURST_INCR, i[0]);
        end
        // random INCR bursts with random strobes in the second half
        for (i = 0; i < 40; i++)
        begin
            addr = ($unsigned($random(seed)) % MEM_DEPTH) * 8 + ($unsigned($random(seed)) % 8);
            len  = $unsigned($random(seed)) % 16;
            id   = 4'($random(seed));
            prep_write(addr, len, axi_mem_pkg::BURST_INCR, i >= 20);
            drive_write(id, addr, len, axi_mem_pkg::BURST_INCR, 1'b1);
            drive_read(id + 4'd1, addr, len, axi_mem_pkg::BURST_INCR, 1'b1);
        end
        // FIXED burst keeps only its last beat in word 0x20
        prep_write(32'h100, 3, axi_mem_pkg::BURST_FIXED, 1'b0);
        drive_write(4'h3, 32'h100, 3, axi_mem_pkg::BURST_FIXED, 1'b1);
        drive_read(4'h4, 32'h100, 0, axi_mem_pkg::BURST_INCR, 1'b1);
        drive_read(4'h5, 32'h100, 3, axi_mem_pkg::BURST_FIXED, 1'b1);
        // WRAP bursts start mid-block and the block is read back by INCR too
        prep_write(32'h208, 3, axi_mem_pkg::BURST_WRAP, 1'b0);
        drive_write(4'h6, 32'h208, 3, axi_mem_pkg::BURST_WRAP, 1'b1);
        drive_read(4'h7, 32'h208, 3, axi_mem_pkg::BURST_WRAP, 1'b1);
        drive_read(4'h8, 32'h200, 3, axi_mem_pkg::BURST_INCR, 1'b1);
        prep_write(32'h2a8, 7, axi_mem_pkg::BURST_WRAP, 1'b1);
        drive_write(4'h9, 32'h2a8, 7, axi_mem_pkg::BURST_WRAP, 1'b1);
        drive_read(4'ha, 32'h2a8, 7, axi_mem_pkg::BURST_WRAP, 1'b1);
        drive_read(4'hb, 32'h280, 7, axi_mem_pkg::BURST_INCR, 1'b1);
        // AW and AR raised together so the read must see the new data
        addr = ($unsigned($random(seed)) % MEM_DEPTH) * 8;
        len  = $unsigned($random(seed)) % 16;
        prep_write(addr, len, axi_mem_pkg::BURST_INCR, 1'b0);
        fork
            drive_write(4'hc, addr, len, axi_mem_pkg::BURST_INCR, 1'b1);
            drive_read(4'hd, addr, len, axi_mem_pkg::BURST_INCR, 1'b1);
        join
        check_count++;
        assert (ar_cycle > b_cycle) else report_problem("read granted before the write finished");
        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0 && check_count > 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* sim.f */
hdl/axi_mem_pkg.sv
hdl/burst_addr_gen.sv
hdl/mem_byte_lane.sv
hdl/axi_write_channel.sv
hdl/axi_read_channel.sv
hdl/axi_mem_top.sv
verif/tb_clock_gen.sv
verif/tb_axi_mem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile the AXI memory testbench with Verilator, run it, judge by the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_mem \
    -f sim.f -o Vtb_axi_mem > "$BUILD_LOG" 2>&1 \
    && ./obj_dir/Vtb_axi_mem > "$SIM_LOG" 2>&1 \
    || { echo "build or run error, see $BUILD_LOG and $SIM_LOG"; exit 1; }

grep -q "^Testbench passed$" "$SIM_LOG" \
    && echo "simulation passed" \
    || { echo "simulation failed, see $SIM_LOG"; exit 1; }
